/* Bender.yml */
package:
  name: pcw_io

sources:
  - pcw_bus_pkg.sv
  - pcw_sys_pkg.sv
  - pcw_io_slave.sv
  - pcw_port_regs.sv
  - pcw_page_mapper.sv
  - pcw_int_ctrl.sv
  - pcw_io_top.sv
  - target: test
    files:
      - tb_pcw_io.sv

/* pcw_bus_pkg.sv */
`default_nettype none

package pcw_bus_pkg;

    typedef logic [7:0] io_addr_t;  // Z80 I/O port number, low byte only
    typedef logic [7:0] io_data_t;

    // Decoded system ports
    typedef enum logic [2:0] {
        PORT_F0   = 3'd0,  // Page 0000-3fff
        PORT_F1   = 3'd1,  // Page 4000-7fff
        PORT_F2   = 3'd2,  // Page 8000-bfff
        PORT_F3   = 3'd3,  // Page c000-ffff
        PORT_F4   = 3'd4,  // CPC read lock, read clears timer
        PORT_F8   = 3'd5,  // System control / status
        PORT_NONE = 3'd7
    } io_port_e;

    localparam io_addr_t ADDR_F0 = 8'hf0;
    localparam io_addr_t ADDR_F1 = 8'hf1;
    localparam io_addr_t ADDR_F2 = 8'hf2;
    localparam io_addr_t ADDR_F3 = 8'hf3;
    localparam io_addr_t ADDR_F4 = 8'hf4;
    localparam io_addr_t ADDR_F8 = 8'hf8;

    localparam io_data_t UNMAPPED_READ = 8'hff;  // Floating bus

    // Wishbone classic request from the master
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        io_addr_t adr;
        io_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        io_data_t dat;  // Valid with ack
    } wb_rsp_t;

    // Single-cycle port write towards the register bank
    typedef struct packed {
        logic     wr;
        io_port_e port;
        io_data_t dat;
    } port_wr_t;

endpackage

`default_nettype wire

/* pcw_int_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module pcw_int_ctrl (
    input  wire                    clk_sys,
    input  wire                    reset,
    input  wire pcw_sys_pkg::sys_ctrl_t sys_ctrl,
    input  wire                    mode_change,
    input  wire                    timer_read,  // F4 read, start clear
    input  wire                    timer_tick,  // 300 Hz from video timing
    input  wire                    fdc_int,
    input  wire                    iff1,        // CPU interrupts enabled
    input  wire                    ntsc,
    output pcw_bus_pkg::io_data_t  status,
    output logic                   int_n,
    output logic                   nmi_n
);

    logic [1:0] in_sync_q, in_prev_q;  // {timer_tick, fdc_int}
    logic timer_rise, fdc_rise, fdc_fall;
    logic fdc_latch_q, nmi_flag_q;
    logic [3:0] timer_misses_q;
    logic timer_line_q, int_line_q, nmi_line_q;
    logic clear_busy_q;
    logic [pcw_sys_pkg::TIMER_CLEAR_W-1:0] clear_cnt_q;
    logic clear_end;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            in_sync_q <= '0;
            in_prev_q <= '0;
        end else begin
            in_sync_q <= {timer_tick, fdc_int};
            in_prev_q <= in_sync_q;
        end
    end

    assign timer_rise = in_sync_q[1] && !in_prev_q[1];
    assign fdc_rise   = in_sync_q[0] && !in_prev_q[0];
    assign fdc_fall   = !in_sync_q[0] && in_prev_q[0];

    // FDC status latch follows the line, NMI flag remembers it
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            fdc_latch_q <= 1'b0;
            nmi_flag_q  <= 1'b0;
        end else begin
            if (fdc_rise) begin
                fdc_latch_q <= 1'b1;
                if (sys_ctrl.disk_to_nmi) nmi_flag_q <= 1'b1;
            end else if (fdc_fall) begin
                fdc_latch_q <= 1'b0;
            end
            if (mode_change && !sys_ctrl.disk_to_nmi) nmi_flag_q <= 1'b0;  // No longer NMI mode
        end
    end

    assign clear_end = clear_busy_q && (clear_cnt_q == pcw_sys_pkg::TIMER_CLEAR_LAST);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            timer_misses_q <= '0;
            timer_line_q   <= 1'b0;
            int_line_q     <= 1'b0;
            nmi_line_q     <= 1'b0;
            clear_busy_q   <= 1'b0;
            clear_cnt_q    <= '0;
        end else begin
            if (timer_rise) begin  // Lines only move on the 300 Hz tick
                if (!(&timer_misses_q)) timer_misses_q <= timer_misses_q + 4'd1;
                timer_line_q <= iff1;
                nmi_line_q   <= nmi_flag_q;
                int_line_q   <= sys_ctrl.disk_to_int && fdc_latch_q && iff1;
            end
            if (timer_read) begin
                clear_busy_q <= 1'b1;  // Restart on every read
                clear_cnt_q  <= '0;
            end else if (clear_end) begin
                clear_busy_q   <= 1'b0;
                timer_line_q   <= 1'b0;  // Wins over a tick in the same cycle
                timer_misses_q <= '0;
            end else if (clear_busy_q) begin
                clear_cnt_q <= clear_cnt_q + 1'b1;
            end
            if (mode_change && !sys_ctrl.disk_to_int) int_line_q <= 1'b0;
        end
    end

    assign status = {2'b00, fdc_latch_q, ~ntsc, timer_misses_q};

    assign nmi_n = !nmi_line_q;
    assign int_n = nmi_line_q || !(int_line_q || timer_line_q);  // Held off while NMI pending

    // Miss count saturates at 15
    misses_saturate: assert property (@(posedge clk_sys) disable iff (reset)
        (timer_rise && (&timer_misses_q) && !clear_end) |=> (&timer_misses_q));

endmodule

`default_nettype wire

/* pcw_io_golden.txt */
# W port data | R port expected | M cpu_addr write mem_size phys_addr | T ticks
# F fdc pulse | C sys_ctrl int_n nmi_n | K clear timer | all fields hex
C 00 1 1
M 4000 0 0 004000
W f2 bf
M 8123 0 3 0fc123
M 8123 0 0 03c123
R 55 ff
W f1 25
W f4 00
M 4010 0 3 008010
M 4010 1 3 014010
W f4 20
M 4010 0 3 014010
T 3
R f8 13
C 00 0 1
T 14
R f8 1f
K
C 00 1 1
W f8 09
W f8 0b
W f8 05
C 07 1 1
W f8 0a
W f8 0c
W f8 06
C 00 1 1
W f8 02
F
T 1
C 10 1 0
W f8 04
C 00 1 0
T 1
C 00 0 1
K
C 00 1 1

/* pcw_io_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module pcw_io_slave (
    input  wire                   clk_sys,
    input  wire                   reset,
    input  wire pcw_bus_pkg::wb_req_t  wb_req,
    output pcw_bus_pkg::wb_rsp_t  wb_rsp,
    input  wire pcw_bus_pkg::io_data_t status,  // Shared F8/F4 status byte
    output pcw_bus_pkg::port_wr_t port_wr,
    output logic                  timer_read     // Read of F4 acked
);

    pcw_bus_pkg::io_port_e port;
    logic ack_q;
    logic armed_q;  // Cleared after ack until stb seen low

    always_comb begin
        case (wb_req.adr)
            pcw_bus_pkg::ADDR_F0: port = pcw_bus_pkg::PORT_F0;
            pcw_bus_pkg::ADDR_F1: port = pcw_bus_pkg::PORT_F1;
            pcw_bus_pkg::ADDR_F2: port = pcw_bus_pkg::PORT_F2;
            pcw_bus_pkg::ADDR_F3: port = pcw_bus_pkg::PORT_F3;
            pcw_bus_pkg::ADDR_F4: port = pcw_bus_pkg::PORT_F4;
            pcw_bus_pkg::ADDR_F8: port = pcw_bus_pkg::PORT_F8;
            default:              port = pcw_bus_pkg::PORT_NONE;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ack_q   <= 1'b0;
            armed_q <= 1'b1;
        end else begin
            ack_q <= wb_req.cyc && wb_req.stb && armed_q && !ack_q;
            if (ack_q)
                armed_q <= 1'b0;  // One ack per strobe
            else if (!wb_req.stb)
                armed_q <= 1'b1;  // Master dropped stb, re-arm
        end
    end

    // Master holds adr/dat through ack, so decode straight off the bus
    assign port_wr.wr   = ack_q && wb_req.we;
    assign port_wr.port = port;
    assign port_wr.dat  = wb_req.dat;

    assign timer_read = ack_q && !wb_req.we && (port == pcw_bus_pkg::PORT_F4);

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = (port == pcw_bus_pkg::PORT_F8 || port == pcw_bus_pkg::PORT_F4) ?
                        status : pcw_bus_pkg::UNMAPPED_READ;

    // Single-cycle ack, never back to back
    ack_single: assert property (@(posedge clk_sys) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack);

    // Ack only answers a strobe seen on the previous edge
    ack_after_stb: assert property (@(posedge clk_sys) disable iff (reset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

`default_nettype wire

/* pcw_io_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pcw_io_top (
    input  wire                         clk_sys,
    input  wire                         reset,
    input  wire pcw_bus_pkg::wb_req_t   wb_req,
    output pcw_bus_pkg::wb_rsp_t        wb_rsp,
    input  wire [15:0]                  cpu_addr,
    input  wire                         cpu_write,
    input  wire pcw_sys_pkg::mem_size_e memory_size,
    input  wire                         ntsc,
    input  wire                         timer_tick,
    input  wire                         fdc_int,
    input  wire                         iff1,
    output pcw_sys_pkg::phys_addr_t     phys_addr,
    output pcw_sys_pkg::sys_ctrl_t      sys_ctrl,
    output logic                        int_n,
    output logic                        nmi_n
);

    pcw_bus_pkg::port_wr_t  port_wr;
    pcw_bus_pkg::io_data_t  status;     // F8/F4 read value
    pcw_sys_pkg::page_cfg_t page_cfg;
    logic timer_read;
    logic mode_change;

    pcw_io_slave pcw_io_slave_inst (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .status     (status),
        .port_wr    (port_wr),
        .timer_read (timer_read)
    );

    pcw_port_regs pcw_port_regs_inst (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .port_wr     (port_wr),
        .page_cfg    (page_cfg),
        .sys_ctrl    (sys_ctrl),
        .mode_change (mode_change)
    );

    pcw_page_mapper pcw_page_mapper_inst (
        .page_cfg    (page_cfg),
        .cpu_addr    (cpu_addr),
        .cpu_write   (cpu_write),
        .memory_size (memory_size),
        .phys_addr   (phys_addr)
    );

    pcw_int_ctrl pcw_int_ctrl_inst (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .sys_ctrl    (sys_ctrl),
        .mode_change (mode_change),
        .timer_read  (timer_read),
        .timer_tick  (timer_tick),
        .fdc_int     (fdc_int),
        .iff1        (iff1),
        .ntsc        (ntsc),
        .status      (status),
        .int_n       (int_n),
        .nmi_n       (nmi_n)
    );

endmodule

`default_nettype wire

/* pcw_page_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module pcw_page_mapper (
    input  wire pcw_sys_pkg::page_cfg_t page_cfg,
    input  wire [15:0]                  cpu_addr,
    input  wire                         cpu_write,
    input  wire pcw_sys_pkg::mem_size_e memory_size,
    output pcw_sys_pkg::phys_addr_t     phys_addr
);

    logic [1:0] sel;  // 16K quarter of CPU space
    pcw_sys_pkg::page_reg_t page;
    logic lock_bit;
    logic [pcw_sys_pkg::PAGE_BITS-1:0] size_mask;
    logic [pcw_sys_pkg::PAGE_BITS-1:0] pcw_page;
    logic [pcw_sys_pkg::CPC_BANK_BITS-1:0] cpc_bank;

    assign sel      = cpu_addr[15:14];
    assign page     = page_cfg.page[sel];
    assign lock_bit = page_cfg.lock[{1'b1, sel}];  // F4 bits 7:4

    always_comb begin
        case (memory_size)
            pcw_sys_pkg::MEM_256K: size_mask = 7'h0f;
            pcw_sys_pkg::MEM_512K: size_mask = 7'h1f;
            pcw_sys_pkg::MEM_1M:   size_mask = 7'h3f;
            default:               size_mask = 7'h7f;  // 2M
        endcase
    end

    assign pcw_page = page[6:0] & size_mask;  // Wrap on smaller machines

    // CPC: write bank in 2:0, read bank in 6:4 unless locked
    assign cpc_bank = (cpu_write || lock_bit) ? page[2:0] : page[6:4];

    assign phys_addr = page[7] ?
        {pcw_page, cpu_addr[pcw_sys_pkg::OFFSET_BITS-1:0]} :
        {{(pcw_sys_pkg::PAGE_BITS - pcw_sys_pkg::CPC_BANK_BITS){1'b0}},
         cpc_bank, cpu_addr[pcw_sys_pkg::OFFSET_BITS-1:0]};

endmodule

`default_nettype wire

/* pcw_port_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module pcw_port_regs (
    input  wire                   clk_sys,
    input  wire                   reset,
    input  wire pcw_bus_pkg::port_wr_t port_wr,
    output pcw_sys_pkg::page_cfg_t page_cfg,
    output pcw_sys_pkg::sys_ctrl_t sys_ctrl,
    output logic                  mode_change  // Disk routing changed, cmd 3 or 4
);

    pcw_sys_pkg::sys_cmd_e cmd;

    assign cmd = pcw_sys_pkg::sys_cmd_e'(port_wr.dat[3:0]);  // Upper nibble ignored

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            page_cfg    <= pcw_sys_pkg::PAGE_RESET;  // PCW mode, pages 0-3
            sys_ctrl    <= '0;
            mode_change <= 1'b0;
        end else begin
            mode_change <= 1'b0;  // Pulse
            if (port_wr.wr) begin
                case (port_wr.port)
                    pcw_bus_pkg::PORT_F0,
                    pcw_bus_pkg::PORT_F1,
                    pcw_bus_pkg::PORT_F2,
                    pcw_bus_pkg::PORT_F3: begin
                        page_cfg.page[port_wr.port[1:0]] <= port_wr.dat;  // Enum code is index
                    end
                    pcw_bus_pkg::PORT_F4: page_cfg.lock <= port_wr.dat;
                    pcw_bus_pkg::PORT_F8: begin
                        case (cmd)
                            pcw_sys_pkg::CMD_END_BOOT: ;  // Nothing to do without boot ROM
                            pcw_sys_pkg::CMD_DISK_NMI: begin
                                sys_ctrl.disk_to_nmi <= 1'b1;
                                sys_ctrl.disk_to_int <= 1'b0;
                            end
                            pcw_sys_pkg::CMD_DISK_INT: begin
                                sys_ctrl.disk_to_nmi <= 1'b0;
                                sys_ctrl.disk_to_int <= 1'b1;
                                mode_change          <= 1'b1;
                            end
                            pcw_sys_pkg::CMD_DISK_OFF: begin
                                sys_ctrl.disk_to_nmi <= 1'b0;
                                sys_ctrl.disk_to_int <= 1'b0;
                                mode_change          <= 1'b1;
                            end
                            pcw_sys_pkg::CMD_TC_SET:    sys_ctrl.tc      <= 1'b1;
                            pcw_sys_pkg::CMD_TC_CLR:    sys_ctrl.tc      <= 1'b0;
                            pcw_sys_pkg::CMD_MOTOR_ON:  sys_ctrl.motor   <= 1'b1;
                            pcw_sys_pkg::CMD_MOTOR_OFF: sys_ctrl.motor   <= 1'b0;
                            pcw_sys_pkg::CMD_SPK_ON:    sys_ctrl.speaker <= 1'b1;
                            pcw_sys_pkg::CMD_SPK_OFF:   sys_ctrl.speaker <= 1'b0;
                            default: ;  // Reset (1) and spare codes
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // Disk interrupt goes one way only
    disk_route_excl: assert property (@(posedge clk_sys) disable iff (reset)
        !(sys_ctrl.disk_to_nmi && sys_ctrl.disk_to_int));

endmodule

`default_nettype wire

/* pcw_sys_pkg.sv */
`default_nettype none

package pcw_sys_pkg;

    // Low nibble of a write to F8
    typedef enum logic [3:0] {
        CMD_END_BOOT  = 4'd0,
        CMD_DISK_NMI  = 4'd2,
        CMD_DISK_INT  = 4'd3,
        CMD_DISK_OFF  = 4'd4,   // Disk neither NMI nor INT
        CMD_TC_SET    = 4'd5,
        CMD_TC_CLR    = 4'd6,
        CMD_MOTOR_ON  = 4'd9,
        CMD_MOTOR_OFF = 4'd10,
        CMD_SPK_ON    = 4'd11,
        CMD_SPK_OFF   = 4'd12
    } sys_cmd_e;

    typedef enum logic [1:0] {
        MEM_256K = 2'd0,  // 4 page bits
        MEM_512K = 2'd1,  // 5 page bits
        MEM_1M   = 2'd2,  // 6 page bits
        MEM_2M   = 2'd3   // 7 page bits
    } mem_size_e;

    localparam int PAGE_BITS     = 7;
    localparam int OFFSET_BITS   = 14;  // 16K pages
    localparam int CPC_BANK_BITS = 3;

    typedef logic [7:0] page_reg_t;
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] phys_addr_t;  // 21 bits, 2M

    typedef struct packed {
        page_reg_t [3:0] page;  // F3 down to F0
        page_reg_t       lock;  // F4, bits 7:4 lock per page
    } page_cfg_t;

    typedef struct packed {
        logic disk_to_nmi;
        logic disk_to_int;
        logic tc;       // FDC terminal count
        logic motor;
        logic speaker;
    } sys_ctrl_t;

    // F3, F2, F1, F0 then lock
    localparam page_cfg_t PAGE_RESET = {8'h83, 8'h82, 8'h81, 8'h80, 8'hf1};

    localparam int TIMER_CLEAR_CYCLES = 32;
    localparam int TIMER_CLEAR_W      = $clog2(TIMER_CLEAR_CYCLES);
    localparam logic [TIMER_CLEAR_W-1:0] TIMER_CLEAR_LAST =
        TIMER_CLEAR_W'(TIMER_CLEAR_CYCLES - 1);

endpackage

`default_nettype wire

/* tb.f */
pcw_bus_pkg.sv
pcw_sys_pkg.sv
pcw_io_slave.sv
pcw_port_regs.sv
pcw_page_mapper.sv
pcw_int_ctrl.sv
pcw_io_top.sv
tb_pcw_io.sv

/* tb_pcw_io.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pcw_io;

    localparam int ACK_TIMEOUT  = 16;  // Cycles allowed for one ack
    localparam int CTRL_TIMEOUT = 8;   // Edge effects land within 3 cycles
    localparam int CLEAR_POLLS  = 40;  // F8 reads while the 32-cycle clear runs

    logic clk_sys;
    logic reset;
    pcw_bus_pkg::wb_req_t wb_req;
    pcw_bus_pkg::wb_rsp_t wb_rsp;
    logic [15:0] cpu_addr;
    logic cpu_write;
    pcw_sys_pkg::mem_size_e memory_size;
    logic ntsc;
    logic timer_tick;
    logic fdc_int;
    logic iff1;
    pcw_sys_pkg::phys_addr_t phys_addr;
    pcw_sys_pkg::sys_ctrl_t sys_ctrl;
    logic int_n;
    logic nmi_n;

    integer fd;
    integer code;
    logic [63:0] tok;         // Operation letter in the low byte
    logic [799:0] rest;       // Remainder of a comment line
    logic [31:0] f0, f1, f2, f3;
    pcw_bus_pkg::io_data_t rd;
    int ops;
    bit done;

    pcw_io_top pcw_io_top_inst (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .cpu_addr    (cpu_addr),
        .cpu_write   (cpu_write),
        .memory_size (memory_size),
        .ntsc        (ntsc),
        .timer_tick  (timer_tick),
        .fdc_int     (fdc_int),
        .iff1        (iff1),
        .phys_addr   (phys_addr),
        .sys_ctrl    (sys_ctrl),
        .int_n       (int_n),
        .nmi_n       (nmi_n)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;  // 50 MHz
    end

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input pcw_bus_pkg::io_data_t got, input pcw_bus_pkg::io_data_t exp,
                              input pcw_bus_pkg::io_addr_t port);
        if (got !== exp)
            fail_with($sformatf("error %0t: port %h read %h, expected %h", $time, port, got, exp));
    endtask

    task automatic check_addr(input pcw_sys_pkg::phys_addr_t got,
                              input pcw_sys_pkg::phys_addr_t exp, input logic [15:0] addr);
        if (got !== exp)
            fail_with($sformatf("error %0t: cpu_addr %h mapped to %h, expected %h",
                                $time, addr, got, exp));
    endtask

    task automatic check_ctrl(input pcw_sys_pkg::sys_ctrl_t got, input logic got_int_n,
                              input logic got_nmi_n, input pcw_sys_pkg::sys_ctrl_t exp,
                              input logic exp_int_n, input logic exp_nmi_n);
        if (got !== exp || got_int_n !== exp_int_n || got_nmi_n !== exp_nmi_n)
            fail_with($sformatf("error %0t: sys_ctrl %b int_n %b nmi_n %b, expected %b %b %b",
                                $time, got, got_int_n, got_nmi_n, exp, exp_int_n, exp_nmi_n));
    endtask

    task automatic need_fields(input integer got, input integer want);
        if (got != want)
            fail_with($sformatf("golden file line after operation %0d is malformed", ops));
    endtask

    // One classic cycle, request held through the ack edge
    task automatic bus_cycle(input logic we, input pcw_bus_pkg::io_addr_t adr,
                             input pcw_bus_pkg::io_data_t dat, output pcw_bus_pkg::io_data_t rdat);
        int waited;
        waited = 0;
        @(negedge clk_sys);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge clk_sys);
        while (!wb_rsp.ack) begin
            if (waited == ACK_TIMEOUT)
                fail_with("timeout waiting for wishbone ack");
            waited++;
            @(negedge clk_sys);
        end
        rdat = wb_rsp.dat;  // Valid mid ack cycle
        @(negedge clk_sys);  // Write lands on the edge just passed
        wb_req = '0;
    endtask

    task automatic map_check(input logic [15:0] addr, input logic wr,
                             input pcw_sys_pkg::mem_size_e size, input pcw_sys_pkg::phys_addr_t exp);
        @(negedge clk_sys);
        cpu_addr    = addr;
        cpu_write   = wr;
        memory_size = size;
        @(negedge clk_sys);  // Mapper is combinational
        check_addr(phys_addr, exp, addr);
    endtask

    task automatic pulse_timer(input int count);
        repeat (count) begin
            @(negedge clk_sys);
            timer_tick = 1'b1;
            repeat (2) @(negedge clk_sys);  // Long enough for the synchronizer
            timer_tick = 1'b0;
            @(negedge clk_sys);
        end
    endtask

    task automatic pulse_fdc();
        @(negedge clk_sys);
        fdc_int = 1'b1;
        repeat (2) @(negedge clk_sys);
        fdc_int = 1'b0;
        repeat (2) @(negedge clk_sys);  // Falling edge clears the latch
    endtask

    task automatic wait_ctrl(input pcw_sys_pkg::sys_ctrl_t exp, input logic exp_int_n,
                             input logic exp_nmi_n);
        int waited;
        waited = 0;
        @(negedge clk_sys);
        while ((sys_ctrl !== exp || int_n !== exp_int_n || nmi_n !== exp_nmi_n)
               && waited < CTRL_TIMEOUT) begin
            waited++;
            @(negedge clk_sys);
        end
        check_ctrl(sys_ctrl, int_n, nmi_n, exp, exp_int_n, exp_nmi_n);
    endtask

    // F4 read then poll F8 until the miss count is gone
    task automatic timer_clear();
        pcw_bus_pkg::io_data_t rdat;
        int polls;
        polls = 0;
        bus_cycle(1'b0, pcw_bus_pkg::ADDR_F4, 8'h00, rdat);
        bus_cycle(1'b0, pcw_bus_pkg::ADDR_F8, 8'h00, rdat);
        while (rdat[3:0] != 4'd0) begin
            if (polls == CLEAR_POLLS)
                fail_with("timeout waiting for the timer miss count to clear");
            polls++;
            bus_cycle(1'b0, pcw_bus_pkg::ADDR_F8, 8'h00, rdat);
        end
    endtask

    initial begin
        wb_req      = '0;
        cpu_addr    = 16'h0000;
        cpu_write   = 1'b0;
        memory_size = pcw_sys_pkg::MEM_256K;
        ntsc        = 1'b0;  // PAL, status bit 4 reads 1
        timer_tick  = 1'b0;
        fdc_int     = 1'b0;
        iff1        = 1'b1;
        reset       = 1'b1;
        ops         = 0;
        done        = 1'b0;
        repeat (16) @(negedge clk_sys);
        reset = 1'b0;

        fd = $fopen("pcw_io_golden.txt", "r");
        if (fd == 0)
            fail_with("cannot open pcw_io_golden.txt");
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;  // End of file
            end else begin
                case (tok[7:0])
                    "#": code = $fgets(rest, fd);
                    "W": begin
                        need_fields($fscanf(fd, "%h %h", f0, f1), 2);
                        bus_cycle(1'b1, f0[7:0], f1[7:0], rd);
                    end
                    "R": begin
                        need_fields($fscanf(fd, "%h %h", f0, f1), 2);
                        bus_cycle(1'b0, f0[7:0], 8'h00, rd);
                        check_data(rd, f1[7:0], f0[7:0]);
                    end
                    "M": begin
                        need_fields($fscanf(fd, "%h %h %h %h", f0, f1, f2, f3), 4);
                        map_check(f0[15:0], f1[0], pcw_sys_pkg::mem_size_e'(f2[1:0]), f3[20:0]);
                    end
                    "T": begin
                        need_fields($fscanf(fd, "%h", f0), 1);
                        pulse_timer(f0);
                    end
                    "F": pulse_fdc();
                    "C": begin
                        need_fields($fscanf(fd, "%h %h %h", f0, f1, f2), 3);
                        wait_ctrl(pcw_sys_pkg::sys_ctrl_t'(f0[4:0]), f1[0], f2[0]);
                    end
                    "K": timer_clear();
                    default: fail_with("unknown operation letter in pcw_io_golden.txt");
                endcase
                if (tok[7:0] != "#")
                    ops++;
            end
        end
        $fclose(fd);

        if (ops == 0) begin
            fail_with("pcw_io_golden.txt held no operations");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
